// File: verilog/hss_link_defines.svh
// --------------------------------------------------
// link widths, k-character codes and APB register map
// for the serial link transmitter, included by the
// package and by every RTL file that needs a constant
// --------------------------------------------------
`ifndef HSS_LINK_DEFINES_SVH
`define HSS_LINK_DEFINES_SVH

// link word and framing widths
`define HSS_WORD_BITS   32
`define HSS_KCH_BITS    4
`define HSS_CHAN_BITS   8
`define HSS_SEQ_BITS    7
`define HSS_IDLE_BITS   24
`define HSS_CFC_BITS    8

// k-character codes, top byte of a control word
`define HSS_KCH_IDLE    8'hBC
`define HSS_KCH_SOF     8'hFB
`define HSS_KCH_ACK     8'h7C
`define HSS_KCH_NAK     8'h1C
`define HSS_KCH_CFC     8'h3C

// k-flags, one per byte, msb byte first
`define HSS_KFLAGS_CTRL 4'b1000
`define HSS_KFLAGS_DATA 4'b0000

// ack request type bit
`define HSS_ACK_T       1'b0
`define HSS_NAK_T       1'b1

// crc-16 ccitt
`define HSS_CRC_POLY    16'h1021
`define HSS_CRC_INIT    16'hFFFF

`define HSS_QUEUE_DEPTH 4
`define HSS_IDLE_RESET  24'hA5A5A5

// APB register offsets
`define HSS_REG_IDLE    4'h0
`define HSS_REG_CFC     4'h4
`define HSS_REG_FCNT    4'h8
`define HSS_REG_STAT    4'hC

`endif

// File: verilog/hss_link_pkg.sv
// --------------------------------------------------
// packed structs shared by the link transmitter RTL
// and its testbench, import with hss_link_pkg::*
// --------------------------------------------------
`include "hss_link_defines.svh"

package hss_link_pkg;

  // incoming packet, one channel and two payload words
  typedef struct packed {
    logic [`HSS_CHAN_BITS-1:0] chan;
    logic [`HSS_WORD_BITS-1:0] data0;
    logic [`HSS_WORD_BITS-1:0] data1;
  } pkt_t;

  // ack or nak request from the receive side
  typedef struct packed {
    logic       ack_type;
    logic [7:0] seq;
  } ack_req_t;

  // one word of a data frame
  typedef struct packed {
    logic [`HSS_WORD_BITS-1:0] data;
    logic [`HSS_KCH_BITS-1:0]  kchr;
    logic                      last;
  } flit_t;

  // serializer side word
  typedef struct packed {
    logic [`HSS_WORD_BITS-1:0] data;
    logic [`HSS_KCH_BITS-1:0]  kchr;
  } hsl_word_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

endpackage

// File: verilog/hss_queue.sv
// --------------------------------------------------
// small circular FIFO with valid/ready on both sides
// payload type set by the T parameter
// --------------------------------------------------
`timescale 1ns/100ps

module hss_queue #(
  parameter type T     = logic [31:0],
  parameter int  DEPTH = 4
) (
  input  logic clk,
  input  logic rst,
  input  T     push_data_i,
  input  logic push_valid_i,
  output logic push_ready_o,
  output T     pop_data_o,
  output logic pop_valid_o,
  input  logic pop_ready_i
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  T              mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          push;
  logic          pop;

  assign push_ready_o = (count != CW'(DEPTH));
  assign pop_valid_o  = (count != '0);
  assign pop_data_o   = mem[rd_ptr];
  assign push         = push_valid_i & push_ready_o;
  assign pop          = pop_valid_o & pop_ready_i;

  // storage, no reset
  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= push_data_i;
  end

  // pointers wrap at DEPTH
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      // simultaneous push and pop leaves count alone
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

endmodule

// File: verilog/hss_frame_asm.sv
// --------------------------------------------------
// frame assembler, turns each queued packet into a
// four-word data frame: header, two payloads, trailer
// the trailer leaves its crc field zero for the tx
// --------------------------------------------------
`timescale 1ns/100ps
`include "hss_link_defines.svh"

module hss_frame_asm
  import hss_link_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  pkt_t  pkt_i,
  input  logic  pkt_valid_i,
  output logic  pkt_ready_o,
  output flit_t flit_o,
  output logic  flit_valid_o,
  input  logic  flit_ready_i
);

  logic [1:0]               word_idx;
  logic [`HSS_SEQ_BITS-1:0] seq_q;
  logic                     flit_xfer;

  // a flit is on offer whenever a packet sits at the queue head
  assign flit_valid_o = pkt_valid_i;
  assign flit_xfer    = flit_valid_o & flit_ready_i;
  // pop only after the trailer has gone
  assign pkt_ready_o  = flit_xfer & (word_idx == 2'd3);

  // word index and frame sequence
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      word_idx <= 2'd0;
      seq_q    <= '0;
    end
    else if (flit_xfer)
    begin
      word_idx <= word_idx + 2'd1;
      // modulo 128 wrap
      if (word_idx == 2'd3)
        seq_q <= seq_q + 1'b1;
    end
  end

  // --------------------------------------------------
  // flit contents per word index
  // --------------------------------------------------
  always_comb
  begin
    flit_o.kchr = `HSS_KFLAGS_DATA;
    flit_o.last = 1'b0;
    case (word_idx)
      2'd0:
      begin
        // sof, channel, sequence, spare byte
        flit_o.data = {`HSS_KCH_SOF, pkt_i.chan, 1'b0, seq_q, 8'h00};
        flit_o.kchr = `HSS_KFLAGS_CTRL;
      end
      2'd1:    flit_o.data = pkt_i.data0;
      2'd2:    flit_o.data = pkt_i.data1;
      default:
      begin
        // crc slot filled downstream
        flit_o.data = '0;
        flit_o.last = 1'b1;
      end
    endcase
  end

endmodule

// File: verilog/hss_crc_gen.sv
// --------------------------------------------------
// running CRC-16 over the words of one frame
// passes non-last words through, puts the finished
// crc into the low half of the last word
// --------------------------------------------------
`timescale 1ns/100ps
`include "hss_link_defines.svh"

module hss_crc_gen (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      crc_go_i,
  input  logic                      crc_last_i,
  input  logic [`HSS_WORD_BITS-1:0] crc_in_i,
  output logic [`HSS_WORD_BITS-1:0] crc_out_o
);

  logic [15:0]               crc_q;
  logic [15:0]               crc_nxt;
  logic [`HSS_WORD_BITS-1:0] crc_word;

  // one word, msb first
  function automatic logic [15:0] crc_step(input logic [15:0] crc,
                                           input logic [`HSS_WORD_BITS-1:0] d);
    logic [15:0] c;
    logic        fb;
    c = crc;
    for (int i = `HSS_WORD_BITS - 1; i >= 0; i--)
    begin
      fb = c[15] ^ d[i];
      c  = {c[14:0], 1'b0} ^ (fb ? `HSS_CRC_POLY : 16'h0000);
    end
    return c;
  endfunction

  // crc field counts as zero in the last word
  assign crc_word  = crc_last_i ? {crc_in_i[31:16], 16'h0000} : crc_in_i;
  assign crc_nxt   = crc_step(crc_q, crc_word);
  assign crc_out_o = crc_last_i ? {crc_in_i[31:16], crc_nxt} : crc_in_i;

  // remainder, restarts after every last word
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      crc_q <= `HSS_CRC_INIT;
    else if (crc_go_i)
      crc_q <= crc_last_i ? `HSS_CRC_INIT : crc_nxt;
  end

endmodule

// File: verilog/hss_frame_tx.sv
// --------------------------------------------------
// frame transmitter, picks one word per hsl_rdy_i
// cycle from data frames, ack/nak, cfc and idle
// data frames are never broken by control words
// --------------------------------------------------
`timescale 1ns/100ps
`include "hss_link_defines.svh"

module hss_frame_tx
  import hss_link_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  flit_t                     flit_i,
  input  logic                      flit_valid_i,
  output logic                      flit_ready_o,
  input  ack_req_t                  ack_i,
  input  logic                      ack_valid_i,
  output logic                      ack_sent_o,
  input  logic [`HSS_CFC_BITS-1:0]  cfc_mask_i,
  input  logic                      cfc_pend_i,
  output logic                      cfc_sent_o,
  input  logic [`HSS_IDLE_BITS-1:0] idle_sentinel_i,
  output logic                      frame_start_o,
  output hsl_word_t                 hsl_o,
  input  logic                      hsl_rdy_i
);

  typedef enum logic {ST_BETWEEN, ST_IN_FRAME} state_e;

  state_e                    state;
  flit_t                     park_flit;
  logic                      park_q;
  flit_t                     frm_cur;
  logic                      frm_vld;
  logic                      send_frm;
  logic                      send_ack;
  logic                      send_cfc;
  logic                      send_idle;
  logic [7:0]                ack_kch;
  logic [`HSS_WORD_BITS-1:0] crc_in;
  logic [`HSS_WORD_BITS-1:0] crc_out;
  logic                      crc_last;

  // --------------------------------------------------
  // frame source, parked flit first
  // --------------------------------------------------
  assign frm_cur      = park_q ? park_flit : flit_i;
  assign frm_vld      = park_q | flit_valid_i;
  // ready drops while a flit is parked
  assign flit_ready_o = ~park_q;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      park_q <= 1'b0;
    else
      park_q <= frm_vld & ~send_frm;
  end

  // capture a refused flit from the assembler
  always_ff @(posedge clk)
  begin
    if (!park_q && flit_valid_i && !send_frm)
      park_flit <= flit_i;
  end

  // --------------------------------------------------
  // word selection
  // --------------------------------------------------
  always_comb
  begin
    send_frm  = 1'b0;
    send_ack  = 1'b0;
    send_cfc  = 1'b0;
    send_idle = 1'b0;
    if (hsl_rdy_i)
    begin
      // open frame runs to its trailer
      if (state == ST_IN_FRAME)
        if (frm_vld)
          send_frm = 1'b1;
        else
          send_idle = 1'b1;
      else if (ack_valid_i)
        send_ack = 1'b1;
      else if (cfc_pend_i)
        send_cfc = 1'b1;
      else if (frm_vld)
        send_frm = 1'b1;
      else
        send_idle = 1'b1;
    end
  end

  assign ack_sent_o = send_ack;
  assign cfc_sent_o = send_cfc;
  assign ack_kch    = (ack_i.ack_type == `HSS_NAK_T) ? `HSS_KCH_NAK : `HSS_KCH_ACK;

  // control words are single-word crc frames
  always_comb
  begin
    if (send_ack)
      crc_in = {ack_kch, ack_i.seq, 16'h0000};
    else if (send_cfc)
      crc_in = {`HSS_KCH_CFC, cfc_mask_i, 16'h0000};
    else
      crc_in = frm_cur.data;
  end

  assign crc_last = send_frm ? frm_cur.last : 1'b1;

  hss_crc_gen crc_gen_0 (
    .clk        (clk),
    .rst        (rst),
    .crc_go_i   (hsl_rdy_i),
    .crc_last_i (crc_last),
    .crc_in_i   (crc_in),
    .crc_out_o  (crc_out)
  );

  // --------------------------------------------------
  // link output, frame state, frame start pulse
  // --------------------------------------------------
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      hsl_o <= '0;
    else if (hsl_rdy_i)
    begin
      if (send_idle)
      begin
        hsl_o.data <= {`HSS_KCH_IDLE, idle_sentinel_i};
        hsl_o.kchr <= `HSS_KFLAGS_CTRL;
      end
      else
      begin
        hsl_o.data <= crc_out;
        hsl_o.kchr <= send_frm ? frm_cur.kchr : `HSS_KFLAGS_CTRL;
      end
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state         <= ST_BETWEEN;
      frame_start_o <= 1'b0;
    end
    else
    begin
      // header word leaving the idle state
      frame_start_o <= send_frm & (state == ST_BETWEEN);
      if (send_frm)
        state <= frm_cur.last ? ST_BETWEEN : ST_IN_FRAME;
    end
  end

endmodule

// File: verilog/hss_reg_bank.sv
// --------------------------------------------------
// APB register bank: idle sentinel, cfc mask with
// pending flag, data frame counter and status
// --------------------------------------------------
`timescale 1ns/100ps
`include "hss_link_defines.svh"

module hss_reg_bank
  import hss_link_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  apb_req_t                  apb_i,
  output apb_rsp_t                  apb_o,
  output logic [`HSS_IDLE_BITS-1:0] idle_sentinel_o,
  output logic [`HSS_CFC_BITS-1:0]  cfc_mask_o,
  output logic                      cfc_pend_o,
  input  logic                      cfc_sent_i,
  input  logic                      frame_start_i
);

  logic        apb_wr;
  logic        addr_hit;
  logic [31:0] fcnt_q;

  // access phase write
  assign apb_wr = apb_i.psel & apb_i.penable & apb_i.pwrite;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      idle_sentinel_o <= `HSS_IDLE_RESET;
      cfc_mask_o      <= '0;
      cfc_pend_o      <= 1'b0;
      fcnt_q          <= '0;
    end
    else
    begin
      if (apb_wr && apb_i.paddr == `HSS_REG_IDLE)
        idle_sentinel_o <= apb_i.pwdata[`HSS_IDLE_BITS-1:0];
      if (apb_wr && apb_i.paddr == `HSS_REG_CFC)
      begin
        cfc_mask_o <= apb_i.pwdata[`HSS_CFC_BITS-1:0];
        cfc_pend_o <= 1'b1;
      end
      // a new write wins over the sent pulse
      else if (cfc_sent_i)
        cfc_pend_o <= 1'b0;
      // wraps at 2^32
      if (frame_start_i)
        fcnt_q <= fcnt_q + 32'd1;
    end
  end

  // --------------------------------------------------
  // read mux and error decode
  // --------------------------------------------------
  always_comb
  begin
    addr_hit     = 1'b1;
    apb_o.prdata = '0;
    case (apb_i.paddr)
      `HSS_REG_IDLE: apb_o.prdata = {{(32 - `HSS_IDLE_BITS){1'b0}}, idle_sentinel_o};
      `HSS_REG_CFC:  apb_o.prdata = {{(32 - `HSS_CFC_BITS){1'b0}}, cfc_mask_o};
      `HSS_REG_FCNT: apb_o.prdata = fcnt_q;
      `HSS_REG_STAT: apb_o.prdata = {31'd0, cfc_pend_o};
      default:       addr_hit = 1'b0;
    endcase
  end

  // no wait states
  assign apb_o.pready  = 1'b1;
  assign apb_o.pslverr = apb_i.psel & apb_i.penable & ~addr_hit;

endmodule

// File: verilog/hss_link_tx_top.sv
// --------------------------------------------------
// link transmitter top: packet and ack queues, frame
// assembler, frame transmitter and APB register bank
// --------------------------------------------------
`timescale 1ns/100ps
`include "hss_link_defines.svh"

module hss_link_tx_top
  import hss_link_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  pkt_t      pkt_i,
  input  logic      pkt_valid_i,
  output logic      pkt_ready_o,
  input  ack_req_t  ack_i,
  input  logic      ack_valid_i,
  output logic      ack_ready_o,
  input  apb_req_t  apb_i,
  output apb_rsp_t  apb_o,
  output hsl_word_t hsl_o,
  input  logic      hsl_rdy_i
);

  // queue heads
  pkt_t                      pkt_head;
  logic                      pkt_head_valid;
  logic                      pkt_pop;
  ack_req_t                  ack_head;
  logic                      ack_head_valid;
  logic                      ack_sent;
  // assembler to transmitter
  flit_t                     flit;
  logic                      flit_valid;
  logic                      flit_ready;
  // register bank side
  logic [`HSS_IDLE_BITS-1:0] idle_sentinel;
  logic [`HSS_CFC_BITS-1:0]  cfc_mask;
  logic                      cfc_pend;
  logic                      cfc_sent;
  logic                      frame_start;

  hss_queue #(.T(pkt_t), .DEPTH(`HSS_QUEUE_DEPTH)) pkt_q (
    .clk          (clk),
    .rst          (rst),
    .push_data_i  (pkt_i),
    .push_valid_i (pkt_valid_i),
    .push_ready_o (pkt_ready_o),
    .pop_data_o   (pkt_head),
    .pop_valid_o  (pkt_head_valid),
    .pop_ready_i  (pkt_pop)
  );

  hss_queue #(.T(ack_req_t), .DEPTH(`HSS_QUEUE_DEPTH)) ack_q (
    .clk          (clk),
    .rst          (rst),
    .push_data_i  (ack_i),
    .push_valid_i (ack_valid_i),
    .push_ready_o (ack_ready_o),
    .pop_data_o   (ack_head),
    .pop_valid_o  (ack_head_valid),
    .pop_ready_i  (ack_sent)
  );

  hss_frame_asm frame_asm_0 (
    .clk          (clk),
    .rst          (rst),
    .pkt_i        (pkt_head),
    .pkt_valid_i  (pkt_head_valid),
    .pkt_ready_o  (pkt_pop),
    .flit_o       (flit),
    .flit_valid_o (flit_valid),
    .flit_ready_i (flit_ready)
  );

  hss_frame_tx frame_tx_0 (
    .clk             (clk),
    .rst             (rst),
    .flit_i          (flit),
    .flit_valid_i    (flit_valid),
    .flit_ready_o    (flit_ready),
    .ack_i           (ack_head),
    .ack_valid_i     (ack_head_valid),
    .ack_sent_o      (ack_sent),
    .cfc_mask_i      (cfc_mask),
    .cfc_pend_i      (cfc_pend),
    .cfc_sent_o      (cfc_sent),
    .idle_sentinel_i (idle_sentinel),
    .frame_start_o   (frame_start),
    .hsl_o           (hsl_o),
    .hsl_rdy_i       (hsl_rdy_i)
  );

  hss_reg_bank reg_bank_0 (
    .clk             (clk),
    .rst             (rst),
    .apb_i           (apb_i),
    .apb_o           (apb_o),
    .idle_sentinel_o (idle_sentinel),
    .cfc_mask_o      (cfc_mask),
    .cfc_pend_o      (cfc_pend),
    .cfc_sent_i      (cfc_sent),
    .frame_start_i   (frame_start)
  );

endmodule

// File: tb/hss_link_tx_props.sv
// --------------------------------------------------
// assertions for the link transmitter, bound to the
// top level; a shadow model follows every word that
// leaves on hsl_o and checks format, crc and order
// --------------------------------------------------
`timescale 1ns/100ps
`include "hss_link_defines.svh"

module hss_link_tx_props
  import hss_link_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input pkt_t      pkt_i,
  input logic      pkt_valid_i,
  input logic      pkt_ready_o,
  input ack_req_t  ack_i,
  input logic      ack_valid_i,
  input logic      ack_ready_o,
  input apb_req_t  apb_i,
  input apb_rsp_t  apb_o,
  input hsl_word_t hsl_o,
  input logic      hsl_rdy_i,
  input logic      cfc_pend_i
);

  // expected packets and ack requests in push order
  pkt_t        pkt_mem [64];
  logic [5:0]  pkt_wr;
  logic [5:0]  pkt_rd;
  ack_req_t    ack_mem [64];
  logic [5:0]  ack_wr;
  logic [5:0]  ack_rd;
  // link word tracking
  logic        rdy_d;
  logic        in_frame;
  logic [1:0]  pos;
  logic [15:0] crc_run;
  logic [6:0]  exp_seq;
  logic [31:0] hdr_cnt;
  // register shadows, and the values seen when a word was chosen
  logic [23:0] sh_idle;
  logic [23:0] exp_idle;
  logic [7:0]  sh_mask;
  logic [7:0]  exp_mask;
  int          fail_cnt = 0;

  // crc-16, poly 0x1021, word shifted out msb first
  function automatic logic [15:0] crc16_word(input logic [15:0] seed,
                                             input logic [31:0] w);
    logic [15:0] r;
    logic [31:0] s;
    logic        top;
    r = seed;
    s = w;
    repeat (32)
    begin
      top = r[15] ^ s[31];
      r   = r << 1;
      if (top)
        r = r ^ 16'h1021;
      s = s << 1;
    end
    return r;
  endfunction

  logic [31:0] wd;
  logic [7:0]  kc;
  pkt_t        exp_pkt;
  ack_req_t    exp_ack;
  logic        is_ack;
  logic        body_ok;
  logic        hdr_ok;
  logic        ctl_legal;
  logic        apb_acc;
  logic        mapped;

  assign wd      = hsl_o.data;
  assign kc      = wd[31:24];
  assign exp_pkt = pkt_mem[pkt_rd];
  assign exp_ack = ack_mem[ack_rd];
  assign is_ack  = (kc == `HSS_KCH_ACK) || (kc == `HSS_KCH_NAK);
  // payloads in order, trailer upper half zero and crc low
  assign body_ok = (hsl_o.kchr == 4'b0000) &&
                   ((pos == 2'd1) ? (wd == exp_pkt.data0) :
                    (pos == 2'd2) ? (wd == exp_pkt.data1) :
                    ((wd[31:16] == 16'h0) &&
                     (wd[15:0] == crc16_word(crc_run, {wd[31:16], 16'h0}))));
  assign hdr_ok  = (pkt_wr != pkt_rd) && (wd[23:16] == exp_pkt.chan) &&
                   (wd[15:8] == {1'b0, exp_seq}) && (wd[7:0] == 8'h00);
  assign ctl_legal = (hsl_o.kchr == 4'b1000) &&
                     ((kc == `HSS_KCH_IDLE) || (kc == `HSS_KCH_SOF) || is_ack ||
                      (kc == `HSS_KCH_CFC));
  assign apb_acc = apb_i.psel & apb_i.penable;
  assign mapped  = (apb_i.paddr == `HSS_REG_IDLE) || (apb_i.paddr == `HSS_REG_CFC) ||
                   (apb_i.paddr == `HSS_REG_FCNT) || (apb_i.paddr == `HSS_REG_STAT);

  // --------------------------------------------------
  // shadow model
  // --------------------------------------------------
  always @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      pkt_wr   <= '0;
      pkt_rd   <= '0;
      ack_wr   <= '0;
      ack_rd   <= '0;
      rdy_d    <= 1'b0;
      in_frame <= 1'b0;
      pos      <= 2'd0;
      crc_run  <= 16'hFFFF;
      exp_seq  <= '0;
      hdr_cnt  <= '0;
      sh_idle  <= 24'hA5A5A5;
      exp_idle <= 24'hA5A5A5;
      sh_mask  <= '0;
      exp_mask <= '0;
    end
    else
    begin
      rdy_d <= hsl_rdy_i;
      // values the transmitter used for the word chosen now
      if (hsl_rdy_i)
      begin
        exp_idle <= sh_idle;
        exp_mask <= sh_mask;
      end
      if (apb_acc && apb_i.pwrite && apb_i.paddr == `HSS_REG_IDLE)
        sh_idle <= apb_i.pwdata[23:0];
      if (apb_acc && apb_i.pwrite && apb_i.paddr == `HSS_REG_CFC)
        sh_mask <= apb_i.pwdata[7:0];
      if (pkt_valid_i && pkt_ready_o)
      begin
        pkt_mem[pkt_wr] <= pkt_i;
        pkt_wr          <= pkt_wr + 1'b1;
      end
      if (ack_valid_i && ack_ready_o)
      begin
        ack_mem[ack_wr] <= ack_i;
        ack_wr          <= ack_wr + 1'b1;
      end
      // a new word is on hsl_o
      if (rdy_d)
      begin
        if (in_frame)
        begin
          if (pos == 2'd3)
          begin
            in_frame <= 1'b0;
            crc_run  <= 16'hFFFF;
            pkt_rd   <= pkt_rd + 1'b1;
          end
          else
          begin
            crc_run <= crc16_word(crc_run, wd);
            pos     <= pos + 2'd1;
          end
        end
        else if (kc == `HSS_KCH_SOF)
        begin
          in_frame <= 1'b1;
          pos      <= 2'd1;
          crc_run  <= crc16_word(crc_run, wd);
          exp_seq  <= exp_seq + 1'b1;
          hdr_cnt  <= hdr_cnt + 32'd1;
        end
        else if (is_ack)
          ack_rd <= ack_rd + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  a_body: assert property (@(posedge clk) disable iff (rst)
    (rdy_d && in_frame) |-> body_ok)
    else begin $error("data frame word wrong or frame interrupted"); fail_cnt++; end

  a_legal: assert property (@(posedge clk) disable iff (rst)
    (rdy_d && !in_frame) |-> ctl_legal)
    else begin $error("unknown k-character or flags between frames"); fail_cnt++; end

  a_idle: assert property (@(posedge clk) disable iff (rst)
    (rdy_d && !in_frame && kc == `HSS_KCH_IDLE) |-> (wd[23:0] == exp_idle))
    else begin $error("idle word does not carry the sentinel"); fail_cnt++; end

  a_hdr: assert property (@(posedge clk) disable iff (rst)
    (rdy_d && !in_frame && kc == `HSS_KCH_SOF) |-> hdr_ok)
    else begin $error("header channel or sequence wrong"); fail_cnt++; end

  a_ctl_crc: assert property (@(posedge clk) disable iff (rst)
    (rdy_d && !in_frame && (is_ack || kc == `HSS_KCH_CFC)) |->
      (wd[15:0] == crc16_word(16'hFFFF, {wd[31:16], 16'h0})))
    else begin $error("control word crc wrong"); fail_cnt++; end

  a_ack: assert property (@(posedge clk) disable iff (rst)
    (rdy_d && !in_frame && is_ack) |->
      ((ack_wr != ack_rd) && (wd[23:16] == exp_ack.seq) &&
       (kc == (exp_ack.ack_type ? `HSS_KCH_NAK : `HSS_KCH_ACK))))
    else begin $error("ack or nak out of order or wrong type"); fail_cnt++; end

  a_cfc: assert property (@(posedge clk) disable iff (rst)
    (rdy_d && !in_frame && kc == `HSS_KCH_CFC) |-> ((wd[23:16] == exp_mask) && !cfc_pend_i))
    else begin $error("cfc mask wrong or still pending"); fail_cnt++; end

  a_fcnt: assert property (@(posedge clk) disable iff (rst)
    (apb_acc && !apb_i.pwrite && apb_i.paddr == `HSS_REG_FCNT) |-> (apb_o.prdata == hdr_cnt))
    else begin $error("frame counter differs from headers seen"); fail_cnt++; end

  a_slverr: assert property (@(posedge clk) disable iff (rst)
    (apb_acc && !mapped) |-> apb_o.pslverr)
    else begin $error("unmapped address without slave error"); fail_cnt++; end

endmodule

bind hss_link_tx_top hss_link_tx_props props_0 (
  .clk         (clk),
  .rst         (rst),
  .pkt_i       (pkt_i),
  .pkt_valid_i (pkt_valid_i),
  .pkt_ready_o (pkt_ready_o),
  .ack_i       (ack_i),
  .ack_valid_i (ack_valid_i),
  .ack_ready_o (ack_ready_o),
  .apb_i       (apb_i),
  .apb_o       (apb_o),
  .hsl_o       (hsl_o),
  .hsl_rdy_i   (hsl_rdy_i),
  .cfc_pend_i  (cfc_pend)
);

// File: tb/hss_link_tx_tb.sv
// --------------------------------------------------
// testbench for the link transmitter
// drives random packets, ack/nak requests and cfc
// writes under a random serializer ready
// the bound assertion module does the checking
// --------------------------------------------------
`timescale 1ns/100ps
`include "hss_link_defines.svh"

module hss_link_tx_tb;
  import hss_link_pkg::*;

  localparam int TIMEOUT  = 200;
  localparam int NUM_PKTS = 20;

  logic      clk = 1'b0;
  logic      rst;
  pkt_t      pkt_i;
  logic      pkt_valid_i;
  logic      pkt_ready_o;
  ack_req_t  ack_i;
  logic      ack_valid_i;
  logic      ack_ready_o;
  apb_req_t  apb_i;
  apb_rsp_t  apb_o;
  hsl_word_t hsl_o;
  logic      hsl_rdy_i = 1'b0;
  logic      rdy_random = 1'b0;
  int        rd_errs = 0;
  int        to_errs = 0;

  hss_link_tx_top uut (
    .clk         (clk),
    .rst         (rst),
    .pkt_i       (pkt_i),
    .pkt_valid_i (pkt_valid_i),
    .pkt_ready_o (pkt_ready_o),
    .ack_i       (ack_i),
    .ack_valid_i (ack_valid_i),
    .ack_ready_o (ack_ready_o),
    .apb_i       (apb_i),
    .apb_o       (apb_o),
    .hsl_o       (hsl_o),
    .hsl_rdy_i   (hsl_rdy_i)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // serializer ready goes random while traffic runs and stays high after
  always @(negedge clk)
  begin
    if (rdy_random)
      hsl_rdy_i = (($urandom % 4) != 0);
    else
      hsl_rdy_i = 1'b1;
  end

  // --------------------------------------------------
  // stimulus tasks
  // --------------------------------------------------
  task automatic push_packet(input pkt_t p);
    int   n;
    logic ok;
    @(negedge clk);
    pkt_i       = p;
    pkt_valid_i = 1'b1;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < TIMEOUT)
    begin
      @(posedge clk);
      ok = pkt_ready_o;
      n++;
    end
    if (!ok)
    begin
      $display("timeout: packet queue never accepted a packet");
      to_errs++;
    end
    @(negedge clk);
    pkt_valid_i = 1'b0;
  endtask

  task automatic push_ack(input ack_req_t a);
    int   n;
    logic ok;
    @(negedge clk);
    ack_i       = a;
    ack_valid_i = 1'b1;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < TIMEOUT)
    begin
      @(posedge clk);
      ok = ack_ready_o;
      n++;
    end
    if (!ok)
    begin
      $display("timeout: ack queue never accepted a request");
      to_errs++;
    end
    @(negedge clk);
    ack_valid_i = 1'b0;
  endtask

  // setup phase then access phase until pready
  task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic slverr);
    int   n;
    logic ok;
    @(negedge clk);
    apb_i.psel    = 1'b1;
    apb_i.penable = 1'b0;
    apb_i.pwrite  = wr;
    apb_i.paddr   = addr;
    apb_i.pwdata  = wdata;
    @(negedge clk);
    apb_i.penable = 1'b1;
    n      = 0;
    ok     = 1'b0;
    rdata  = '0;
    slverr = 1'b0;
    while (!ok && n < TIMEOUT)
    begin
      @(posedge clk);
      ok     = apb_o.pready;
      rdata  = apb_o.prdata;
      slverr = apb_o.pslverr;
      n++;
    end
    if (!ok)
    begin
      $display("timeout: APB access never completed");
      to_errs++;
    end
    @(negedge clk);
    apb_i = '0;
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial
  begin
    pkt_t        p;
    ack_req_t    a;
    logic [31:0] rd;
    logic        err;
    int          n;
    int          asrt_errs;
    void'($urandom(32'h797c_aa69));
    rst         = 1'b1;
    pkt_i       = '0;
    pkt_valid_i = 1'b0;
    ack_i       = '0;
    ack_valid_i = 1'b0;
    apb_i       = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    apb_xfer(1'b1, `HSS_REG_IDLE, {8'h00, 24'($urandom)}, rd, err);
    rdy_random = 1'b1;
    for (int i = 0; i < NUM_PKTS; i++)
    begin
      p.chan  = 8'($urandom);
      p.data0 = $urandom;
      p.data1 = $urandom;
      push_packet(p);
      // six acks and two cfc writes mixed in
      if (i % 3 == 2)
      begin
        a.ack_type = 1'($urandom);
        a.seq      = 8'($urandom);
        push_ack(a);
      end
      if (i == 6 || i == 14)
        apb_xfer(1'b1, `HSS_REG_CFC, {24'h0, 8'($urandom)}, rd, err);
    end
    rdy_random = 1'b0;

    // drain until every frame has started
    n  = 0;
    rd = '0;
    while (rd != 32'(NUM_PKTS) && n < TIMEOUT)
    begin
      apb_xfer(1'b0, `HSS_REG_FCNT, 32'h0, rd, err);
      n++;
    end
    if (rd != 32'(NUM_PKTS))
    begin
      $display("timeout: frame counter never reached the packet count");
      to_errs++;
      $display("[FAIL] fcnt_rd got %h expected %h", rd, 32'(NUM_PKTS));
      rd_errs++;
    end
    apb_xfer(1'b0, `HSS_REG_STAT, 32'h0, rd, err);
    if (rd != 32'h0)
    begin
      $display("[FAIL] stat_rd got %h expected %h", rd, 32'h0);
      rd_errs++;
    end
    apb_xfer(1'b0, 4'h2, 32'h0, rd, err);
    if (!err)
    begin
      $display("unmapped APB address gave no slave error");
      rd_errs++;
    end

    repeat (4) @(posedge clk);
    asrt_errs = uut.props_0.fail_cnt;
    $display("errors: readback %0d, timeout %0d, assertion %0d", rd_errs, to_errs, asrt_errs);
    if (rd_errs + to_errs + asrt_errs == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  // overall run limit
  initial
  begin
    #2000000;
    $display("timeout: simulation ran past its limit");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: hss_link_tx.f
+incdir+verilog
verilog/hss_link_pkg.sv
verilog/hss_queue.sv
verilog/hss_frame_asm.sv
verilog/hss_crc_gen.sv
verilog/hss_frame_tx.sv
verilog/hss_reg_bank.sv
verilog/hss_link_tx_top.sv
tb/hss_link_tx_props.sv
tb/hss_link_tx_tb.sv
